// File: src/vend_pkg.sv
package vend_pkg;

  // ------------------------------
  // Widths with a meaning
  // ------------------------------
  typedef logic [7:0]  coin_t;
  typedef logic [7:0]  item_id_t;
  typedef logic [6:0]  price_t;
  typedef logic [7:0]  count_t;
  typedef logic [15:0] balance_t;

  // Accepted coin denominations, in ascending value order
  typedef enum logic [1:0] {
    ONE,
    TWO,
    FIVE,
    TEN
  } denom_e;

  // Sale FSM states
  typedef enum logic [2:0] {
    IDLE,
    PROCESS,
    INCREMENT,
    SERV,
    EJECT
  } state_e;

  // ------------------------------
  // Item catalogue
  // ------------------------------
  localparam int NUM_ITEMS = 8;

  // Price per item id
  localparam price_t ITEM_PRICES [NUM_ITEMS] = '{
    7'd3, 7'd7, 7'd12, 7'd15, 7'd20, 7'd26, 7'd33, 7'd40
  };

  // Special selection ids
  localparam item_id_t ITEM_RETURN_ID = 8'hFF;
  localparam item_id_t ITEM_REFUSE_ID = 8'hFE;

  // Face value of a denomination
  function automatic coin_t denom_value(denom_e d);
    case (d)
      ONE:     return 8'd1;
      TWO:     return 8'd2;
      FIVE:    return 8'd5;
      default: return 8'd10;
    endcase
  endfunction

  // Sale check result for the selected item
  typedef struct packed {
    logic   sellable;
    price_t price;
  } sale_check_t;

  // Next change coin chosen by the coin store
  typedef struct packed {
    logic   found;
    denom_e denom;
  } change_pick_t;

endpackage

// File: src/coin_intake.sv
`timescale 1ns/100ps

module coin_intake
  import vend_pkg::*;
(
  input  logic   clk_i,
  input  logic   hard_areset_n_i,
  input  coin_t  coin_i,
  input  logic   coin_take_i,
  output coin_t  coin_o,
  output denom_e denom_o,
  output logic   coin_ok_o
);

  // Coin held since the last handshake
  coin_t coin_q;

  // ------------------------------
  // Coin register
  // ------------------------------
  always_ff @(posedge clk_i or negedge hard_areset_n_i) begin
    if (!hard_areset_n_i) begin
      coin_q <= '0;
    end else if (coin_take_i) begin
      // Latch only on an accepted handshake
      coin_q <= coin_i;
    end
  end

  // ------------------------------
  // Denomination decode
  // ------------------------------
  always_comb begin
    // Default is "not a coin"
    denom_o   = ONE;
    coin_ok_o = 1'b0;
    case (coin_q)
      8'd1: begin
        denom_o   = ONE;
        coin_ok_o = 1'b1;
      end
      8'd2: begin
        denom_o   = TWO;
        coin_ok_o = 1'b1;
      end
      8'd5: begin
        denom_o   = FIVE;
        coin_ok_o = 1'b1;
      end
      8'd10: begin
        denom_o   = TEN;
        coin_ok_o = 1'b1;
      end
      default: begin
        // Foreign value, handed back unchanged later
        coin_ok_o = 1'b0;
      end
    endcase
  end

  // Raw value goes back out on a reject
  assign coin_o = coin_q;

endmodule

// File: src/coin_store.sv
`timescale 1ns/100ps

module coin_store
  import vend_pkg::*;
#(
  parameter int COIN_CAPACITY   = 128,
  parameter int INIT_COIN_COUNT = 20
) (
  input  logic         clk_i,
  input  logic         hard_areset_n_i,
  input  logic         credit_i,
  input  logic         debit_i,
  input  denom_e       denom_i,
  input  balance_t     change_i,
  output change_pick_t pick_o,
  output logic [3:0]   full_o
);

  // One counter per denomination, indexed by denom_e
  count_t counts [4];

  // ------------------------------
  // Coin counters
  // ------------------------------
  always_ff @(posedge clk_i or negedge hard_areset_n_i) begin
    if (!hard_areset_n_i) begin
      for (int d = 0; d < 4; d++) begin
        counts[d] <= count_t'(INIT_COIN_COUNT);
      end
    end else if (credit_i) begin
      // Accepted coin drops into its tube
      counts[denom_i] <= counts[denom_i] + 1'b1;
    end else if (debit_i) begin
      // Change coin leaves the tube
      counts[denom_i] <= counts[denom_i] - 1'b1;
    end
  end

  // ------------------------------
  // Tube full flags
  // ------------------------------
  always_comb begin
    for (int d = 0; d < 4; d++) begin
      full_o[d] = counts[d] >= count_t'(COIN_CAPACITY);
    end
  end

  // ------------------------------
  // Greedy change choice
  // ------------------------------
  always_comb begin
    pick_o.found = 1'b0;
    pick_o.denom = ONE;
    // Ascending scan, so the largest fitting coin wins
    for (int d = 0; d < 4; d++) begin
      if ((counts[d] != '0) &&
          (balance_t'(denom_value(denom_e'(d))) <= change_i)) begin
        pick_o.found = 1'b1;
        pick_o.denom = denom_e'(d);
      end
    end
  end

endmodule

// File: src/item_store.sv
`timescale 1ns/100ps

module item_store
  import vend_pkg::*;
#(
  parameter int INIT_ITEM_COUNT = 5
) (
  input  logic        clk_i,
  input  logic        hard_areset_n_i,
  input  item_id_t    item_id_i,
  input  balance_t    balance_i,
  input  logic        sell_i,
  output sale_check_t check_o
);

  // Stock per item id
  count_t stock [NUM_ITEMS];

  // Table index from the low id bits
  logic [2:0] idx;
  logic       id_in_range;
  logic       in_stock;

  assign idx         = item_id_i[2:0];
  assign id_in_range = item_id_i < item_id_t'(NUM_ITEMS);
  assign in_stock    = stock[idx] != '0;

  // ------------------------------
  // Stock counters
  // ------------------------------
  always_ff @(posedge clk_i or negedge hard_areset_n_i) begin
    if (!hard_areset_n_i) begin
      for (int i = 0; i < NUM_ITEMS; i++) begin
        stock[i] <= count_t'(INIT_ITEM_COUNT);
      end
    end else if (sell_i) begin
      // One item leaves per sale
      stock[idx] <= stock[idx] - 1'b1;
    end
  end

  // ------------------------------
  // Sale check
  // ------------------------------
  always_comb begin
    check_o.price    = ITEM_PRICES[idx];
    // Real item, in stock, and paid for
    check_o.sellable = id_in_range && in_stock &&
                       (balance_t'(ITEM_PRICES[idx]) <= balance_i);
  end

endmodule

// File: src/vend_fsm.sv
`timescale 1ns/100ps

module vend_fsm
  import vend_pkg::*;
(
  input  logic         clk_i,
  input  logic         hard_areset_n_i,
  // Coin input handshake
  input  logic         coin_valid_i,
  output logic         coin_ready_o,
  // Selection input handshake
  input  item_id_t     item_id_i,
  input  logic         item_valid_i,
  output logic         item_ready_o,
  // From coin intake
  input  coin_t        coin_o,
  input  denom_e       denom_o,
  input  logic         coin_ok_o,
  // From coin and item stores
  input  logic [3:0]   full_i,
  input  change_pick_t pick_i,
  input  sale_check_t  check_i,
  // To coin intake and coin store
  output logic         coin_take_o,
  output logic         credit_o,
  output logic         debit_o,
  output denom_e       store_denom_o,
  output balance_t     change_o,
  // To item store
  output item_id_t     sel_id_o,
  output balance_t     balance_o,
  output logic         sell_o,
  // Output strobes
  output item_id_t     item_id_o,
  output logic         item_valid_o,
  output coin_t        coin_out_o,
  output logic         coin_out_valid_o
);

  state_e   state_q;
  state_e   state_d;
  balance_t balance_q;
  balance_t change_q;
  item_id_t sel_id_q;
  logic     reject_q;

  logic     item_take;
  logic     coin_bad;
  logic     pay_coin;
  balance_t pay_value;

  // ------------------------------
  // Handshakes
  // ------------------------------
  assign coin_ready_o = state_q == IDLE;
  // Coin wins over a selection in the same cycle
  assign item_ready_o = (state_q == IDLE) && !coin_valid_i;
  assign coin_take_o  = coin_valid_i && coin_ready_o;
  assign item_take    = item_valid_i && item_ready_o;

  // Foreign value or tube already full
  assign coin_bad = !coin_ok_o || full_i[denom_o];

  // Change coin this cycle, only after a rejected coin is out
  assign pay_coin  = (state_q == EJECT) && !reject_q &&
                     (change_q != '0) && pick_i.found;
  assign pay_value = balance_t'(denom_value(pick_i.denom));

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (coin_take_o) begin
          state_d = PROCESS;
        end else if (item_take) begin
          state_d = SERV;
        end
      end
      PROCESS:   state_d = coin_bad ? EJECT : INCREMENT;
      INCREMENT: state_d = IDLE;
      SERV:      state_d = EJECT;
      EJECT: begin
        if (reject_q) begin
          state_d = (change_q != '0) ? EJECT : IDLE;
        end else if (pay_coin) begin
          // Leave as soon as the last coin is out
          state_d = (change_q != pay_value) ? EJECT : IDLE;
        end else begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge hard_areset_n_i) begin
    if (!hard_areset_n_i) begin
      state_q   <= IDLE;
      balance_q <= '0;
      change_q  <= '0;
      sel_id_q  <= '0;
      reject_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (item_take) begin
        sel_id_q <= item_id_i;
      end
      // Bad coin is flagged for return
      if ((state_q == PROCESS) && coin_bad) begin
        reject_q <= 1'b1;
      end else if (state_q == EJECT) begin
        reject_q <= 1'b0;
      end
      if (state_q == INCREMENT) begin
        balance_q <= balance_q + balance_t'(denom_value(denom_o));
      end else if (state_q == SERV) begin
        // Deposit is spent or refunded either way
        balance_q <= '0;
        change_q  <= check_i.sellable ?
                     balance_q - balance_t'(check_i.price) : balance_q;
      end else if (pay_coin) begin
        change_q <= change_q - pay_value;
      end
    end
  end

  // ------------------------------
  // Store controls
  // ------------------------------
  assign credit_o      = state_q == INCREMENT;
  assign debit_o       = pay_coin;
  assign store_denom_o = (state_q == EJECT) ? pick_i.denom : denom_o;
  assign change_o      = change_q;
  assign sel_id_o      = sel_id_q;
  assign balance_o     = balance_q;
  assign sell_o        = (state_q == SERV) && check_i.sellable;

  // ------------------------------
  // Output strobes
  // ------------------------------
  // Unsold selections report return or refusal
  assign item_id_o = check_i.sellable ? sel_id_q :
                     (sel_id_q == ITEM_RETURN_ID) ? ITEM_RETURN_ID : ITEM_REFUSE_ID;
  assign item_valid_o = state_q == SERV;

  // Rejected coin goes out unchanged, before any change
  assign coin_out_o       = reject_q ? coin_o : denom_value(pick_i.denom);
  assign coin_out_valid_o = ((state_q == EJECT) && reject_q) || pay_coin;

endmodule

// File: src/vend_top.sv
`timescale 1ns/100ps

module vend_top
  import vend_pkg::*;
#(
  parameter int COIN_CAPACITY   = 128,
  parameter int INIT_COIN_COUNT = 20,
  parameter int INIT_ITEM_COUNT = 5
) (
  input  logic     clk_i,
  input  logic     hard_areset_n_i,
  // Coin input
  input  coin_t    coin_i,
  input  logic     coin_valid_i,
  output logic     coin_ready_o,
  // Selection input
  input  item_id_t item_id_i,
  input  logic     item_valid_i,
  output logic     item_ready_o,
  // Item result strobe
  output item_id_t item_id_o,
  output logic     item_valid_o,
  // Ejected coin strobe
  output coin_t    coin_out_o,
  output logic     coin_out_valid_o
);

  // ------------------------------
  // Internal wires
  // ------------------------------
  logic         coin_take;
  coin_t        coin;
  denom_e       denom;
  logic         coin_ok;
  logic         credit;
  logic         debit;
  denom_e       store_denom;
  balance_t     change;
  change_pick_t pick;
  logic [3:0]   full;
  item_id_t     sel_id;
  balance_t     balance;
  logic         sell;
  sale_check_t  check;

  // Coin register and decode
  coin_intake u_coin_intake (
    .clk_i           (clk_i),
    .hard_areset_n_i (hard_areset_n_i),
    .coin_i          (coin_i),
    .coin_take_i     (coin_take),
    .coin_o          (coin),
    .denom_o         (denom),
    .coin_ok_o       (coin_ok)
  );

  // Coin tubes and change choice
  coin_store #(
    .COIN_CAPACITY   (COIN_CAPACITY),
    .INIT_COIN_COUNT (INIT_COIN_COUNT)
  ) u_coin_store (
    .clk_i           (clk_i),
    .hard_areset_n_i (hard_areset_n_i),
    .credit_i        (credit),
    .debit_i         (debit),
    .denom_i         (store_denom),
    .change_i        (change),
    .pick_o          (pick),
    .full_o          (full)
  );

  // Item stock and sale check
  item_store #(
    .INIT_ITEM_COUNT (INIT_ITEM_COUNT)
  ) u_item_store (
    .clk_i           (clk_i),
    .hard_areset_n_i (hard_areset_n_i),
    .item_id_i       (sel_id),
    .balance_i       (balance),
    .sell_i          (sell),
    .check_o         (check)
  );

  // Sale FSM
  vend_fsm u_vend_fsm (
    .clk_i            (clk_i),
    .hard_areset_n_i  (hard_areset_n_i),
    .coin_valid_i     (coin_valid_i),
    .coin_ready_o     (coin_ready_o),
    .item_id_i        (item_id_i),
    .item_valid_i     (item_valid_i),
    .item_ready_o     (item_ready_o),
    .coin_o           (coin),
    .denom_o          (denom),
    .coin_ok_o        (coin_ok),
    .full_i           (full),
    .pick_i           (pick),
    .check_i          (check),
    .coin_take_o      (coin_take),
    .credit_o         (credit),
    .debit_o          (debit),
    .store_denom_o    (store_denom),
    .change_o         (change),
    .sel_id_o         (sel_id),
    .balance_o        (balance),
    .sell_o           (sell),
    .item_id_o        (item_id_o),
    .item_valid_o     (item_valid_o),
    .coin_out_o       (coin_out_o),
    .coin_out_valid_o (coin_out_valid_o)
  );

endmodule

// File: tb/vend_asserts.sv
`timescale 1ns/100ps

module vend_asserts (
  input logic clk_i,
  input logic hard_areset_n_i,
  input logic coin_valid_i,
  input logic item_ready_o,
  input logic item_valid_o,
  input logic coin_out_valid_o
);

  // Failed property count
  int fail_count = 0;

  // ------------------------------
  // Output strobes
  // ------------------------------
  // Result strobe is a single pulse
  item_pulse_a : assert property (@(posedge clk_i) disable iff (!hard_areset_n_i)
    item_valid_o |=> !item_valid_o)
    else begin
      $error("item_valid_o stayed high for more than one cycle");
      fail_count++;
    end

  // Result and coin strobes never share a cycle
  strobe_excl_a : assert property (@(posedge clk_i) disable iff (!hard_areset_n_i)
    !(item_valid_o && coin_out_valid_o))
    else begin
      $error("item_valid_o and coin_out_valid_o high together");
      fail_count++;
    end

  // ------------------------------
  // Input handshakes
  // ------------------------------
  // A pending coin blocks the selection
  coin_first_a : assert property (@(posedge clk_i) disable iff (!hard_areset_n_i)
    coin_valid_i |-> !item_ready_o)
    else begin
      $error("item_ready_o high while coin_valid_i is high");
      fail_count++;
    end

  // Nothing leaves the machine in reset
  reset_quiet_a : assert property (@(posedge clk_i)
    !hard_areset_n_i |-> (!item_valid_o && !coin_out_valid_o))
    else begin
      $error("output valid high during reset");
      fail_count++;
    end

endmodule

bind vend_top vend_asserts u_asserts (
  .clk_i            (clk_i),
  .hard_areset_n_i  (hard_areset_n_i),
  .coin_valid_i     (coin_valid_i),
  .item_ready_o     (item_ready_o),
  .item_valid_o     (item_valid_o),
  .coin_out_valid_o (coin_out_valid_o)
);

// File: tb/tb_vend.sv
`timescale 1ns/100ps

module tb_vend
  import vend_pkg::*;
();

  localparam int WAIT_LIMIT = 100;
  localparam int ITEM_STOCK = 2;

  logic     clk_i;
  logic     hard_areset_n_i;
  coin_t    coin_i;
  logic     coin_valid_i;
  logic     coin_ready_o;
  item_id_t item_id_i;
  logic     item_valid_i;
  logic     item_ready_o;
  item_id_t item_id_o;
  logic     item_valid_o;
  coin_t    coin_out_o;
  logic     coin_out_valid_o;

  // Reference model of deposit and item stock
  int       balance_m;
  int       stock_m [NUM_ITEMS];

  // Strobes seen since the last check
  coin_t    ejected [$];
  item_id_t results [$];

  // Accepted coin values, ascending
  coin_t    denoms [4] = '{8'd1, 8'd2, 8'd5, 8'd10};

  vend_top #(
    .INIT_ITEM_COUNT (ITEM_STOCK)
  ) dut (
    .clk_i            (clk_i),
    .hard_areset_n_i  (hard_areset_n_i),
    .coin_i           (coin_i),
    .coin_valid_i     (coin_valid_i),
    .coin_ready_o     (coin_ready_o),
    .item_id_i        (item_id_i),
    .item_valid_i     (item_valid_i),
    .item_ready_o     (item_ready_o),
    .item_id_o        (item_id_o),
    .item_valid_o     (item_valid_o),
    .coin_out_o       (coin_out_o),
    .coin_out_valid_o (coin_out_valid_o)
  );

  // ------------------------------
  // Clock and strobe monitor
  // ------------------------------
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (dut.u_asserts.fail_count != 0) begin
      abort_run("A protocol assertion in vend_asserts failed");
    end
    if (coin_out_valid_o) begin
      ejected.push_back(coin_out_o);
    end
    if (item_valid_o) begin
      results.push_back(item_id_o);
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  function automatic logic is_denom(input coin_t c);
    return (c == 8'd1) || (c == 8'd2) || (c == 8'd5) || (c == 8'd10);
  endfunction

  // Random accepted coin no larger than limit
  function automatic coin_t random_coin_upto(input int limit);
    int fits;
    fits = 0;
    foreach (denoms[i]) begin
      if (denoms[i] <= limit) begin
        fits++;
      end
    end
    return denoms[$urandom_range(fits - 1, 0)];
  endfunction

  // Random item with at least min_stock left
  function automatic item_id_t pick_item(input int min_stock);
    item_id_t id;
    id = item_id_t'($urandom_range(NUM_ITEMS - 1, 0));
    for (int n = 0; n < NUM_ITEMS; n++) begin
      if (stock_m[id] >= min_stock) begin
        break;
      end
      id = item_id_t'((id + 1) % NUM_ITEMS);
    end
    return id;
  endfunction

  // Coin ready, or selection ready, within the limit
  task automatic wait_ready(input logic use_item, input string what);
    int cycles;
    cycles = 0;
    while (!(use_item ? item_ready_o : coin_ready_o)) begin
      if (cycles >= WAIT_LIMIT) begin
        abort_run($sformatf("Timeout: DUT not ready after %0d cycles (%s)",
                            WAIT_LIMIT, what));
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  // Change coins valid, non-increasing, summing to the expected amount
  task automatic check_coins(input int expected);
    int sum;
    sum = 0;
    foreach (ejected[i]) begin
      assert (is_denom(ejected[i]))
        else abort_run($sformatf("Error at %0t: change coin %0d is no denomination",
                                 $time, ejected[i]));
      if (i > 0) begin
        assert (ejected[i] <= ejected[i - 1])
          else abort_run($sformatf("Error at %0t: change coin %0d after %0d",
                                   $time, ejected[i], ejected[i - 1]));
      end
      sum += ejected[i];
    end
    assert (sum == expected)
      else abort_run($sformatf("Error at %0t: coins out sum %0d, expected %0d",
                               $time, sum, expected));
    ejected.delete();
  endtask

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  task automatic insert_coin(input coin_t value);
    wait_ready(1'b0, "coin in");
    coin_i       = value;
    coin_valid_i = 1'b1;
    @(negedge clk_i);
    coin_valid_i = 1'b0;
    coin_i       = '0;
    wait_ready(1'b0, "coin done");
    if (is_denom(value)) begin
      balance_m += value;
      assert (ejected.size() == 0)
        else abort_run($sformatf("Error at %0t: good coin %0d was ejected", $time, value));
    end else begin
      // Foreign value comes back once, unchanged
      assert ((ejected.size() == 1) && (ejected[0] == value))
        else abort_run($sformatf("Error at %0t: coin %0d not returned once unchanged",
                                 $time, value));
    end
    ejected.delete();
  endtask

  task automatic insert_amount(input int amount);
    int    remaining;
    coin_t c;
    remaining = amount;
    while (remaining > 0) begin
      c = random_coin_upto(remaining);
      insert_coin(c);
      remaining -= c;
    end
  endtask

  // Random coins until the deposit exceeds the price
  task automatic insert_over(input int price);
    while (balance_m <= price) begin
      insert_coin(denoms[$urandom_range(3, 0)]);
    end
  endtask

  task automatic select_item(input item_id_t id);
    item_id_t exp_id;
    int       exp_change;
    // Expected result from the sale rules
    if (id == ITEM_RETURN_ID) begin
      exp_id     = id;
      exp_change = balance_m;
    end else if ((id < NUM_ITEMS) && (stock_m[id] > 0) &&
                 (int'(ITEM_PRICES[id]) <= balance_m)) begin
      exp_id     = id;
      exp_change = balance_m - int'(ITEM_PRICES[id]);
      stock_m[id]--;
    end else begin
      exp_id     = ITEM_REFUSE_ID;
      exp_change = balance_m;
    end
    balance_m = 0;
    wait_ready(1'b1, "selection in");
    item_id_i    = id;
    item_valid_i = 1'b1;
    @(negedge clk_i);
    item_valid_i = 1'b0;
    wait_ready(1'b1, "selection done");
    assert (results.size() == 1)
      else abort_run($sformatf("Error at %0t: %0d item strobes, expected 1",
                               $time, results.size()));
    assert (results[0] == exp_id)
      else abort_run($sformatf("Error at %0t: item_id_o %0h, expected %0h",
                               $time, results[0], exp_id));
    results.delete();
    check_coins(exp_change);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    item_id_t id;
    void'($urandom(32'h28ea7b34));
    hard_areset_n_i = 1'b0;
    coin_i          = '0;
    coin_valid_i    = 1'b0;
    item_id_i       = '0;
    item_valid_i    = 1'b0;
    balance_m       = 0;
    foreach (stock_m[i]) begin
      stock_m[i] = ITEM_STOCK;
    end
    repeat (2) @(negedge clk_i);
    hard_areset_n_i = 1'b1;
    @(negedge clk_i);

    // Foreign coins, then a purchase on an unchanged deposit
    insert_coin(8'd3);
    insert_coin(8'd18);
    id = pick_item(1);
    insert_amount(ITEM_PRICES[id]);
    select_item(id);

    // Exact purchases
    repeat (3) begin
      id = pick_item(1);
      insert_amount(ITEM_PRICES[id]);
      select_item(id);
    end

    // Purchases with change
    repeat (3) begin
      id = pick_item(1);
      insert_over(ITEM_PRICES[id]);
      select_item(id);
    end

    // Deposit short of the price
    id = item_id_t'($urandom_range(NUM_ITEMS - 1, 1));
    insert_amount($urandom_range(int'(ITEM_PRICES[id]) - 1, 1));
    select_item(id);

    // Deposit return
    insert_amount($urandom_range(25, 1));
    select_item(ITEM_RETURN_ID);

    // Two sales empty the item, the third is refused
    id = pick_item(ITEM_STOCK);
    repeat (ITEM_STOCK + 1) begin
      insert_amount(ITEM_PRICES[id]);
      select_item(id);
    end

    if (dut.u_asserts.fail_count != 0) begin
      abort_run("A protocol assertion in vend_asserts failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: src.f
src/vend_pkg.sv
src/coin_intake.sv
src/coin_store.sv
src/item_store.sv
src/vend_fsm.sv
src/vend_top.sv
tb/vend_asserts.sv
tb/tb_vend.sv
